// File: Bender.yml
package:
  name: ifetch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ifetch_pkg.sv
      - rtl/imem_block.sv
      - rtl/icache.sv
      - rtl/ifetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/ifetch_chk.sv
      - testbench/ifetch_tb.sv

// File: ifetch_top.f
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/imem_block.sv
rtl/icache.sv
rtl/ifetch_top.sv
testbench/ifetch_chk.sv
testbench/ifetch_tb.sv

// File: rtl/icache.sv
`timescale 1ns/100ps

`include "ifetch_macros.svh"

module icache (
    input  logic                clk,
    input  logic                rst,

    // core side
    input  logic                cpu_req,
    input  ifetch_pkg::addr_t   cpu_addr,
    input  logic                fence_i,
    output ifetch_pkg::word_t   cpu_data,
    output logic                cpu_ready,
    output logic                cpu_hit,

    // refill side
    output logic                mem_req,
    output ifetch_pkg::addr_t   mem_addr,
    input  ifetch_pkg::block_t  mem_data,
    input  logic                mem_ready
);

    ifetch_pkg::ic_state_e  state;
    ifetch_pkg::ic_state_e  next_state;

    ifetch_pkg::ic_tag_t    tag_array [`IC_SETS];
    ifetch_pkg::block_t     data_array [`IC_SETS];
    logic [`IC_SETS-1:0]    valid;

    ifetch_pkg::ic_index_t  index;
    ifetch_pkg::ic_tag_t    tag;
    logic [`IC_WORD_BITS-1:0] word_sel;
    ifetch_pkg::word_t      hit_word;
    ifetch_pkg::word_t      fill_word;
    logic                   fill_done;

    // address split
    assign index    = cpu_addr[`IC_OFFSET_BITS +: `IC_INDEX_BITS];
    assign tag      = cpu_addr[`IC_OFFSET_BITS + `IC_INDEX_BITS +: $bits(ifetch_pkg::ic_tag_t)];
    assign word_sel = cpu_addr[2 +: `IC_WORD_BITS];

    // block aligned refill address
    assign mem_addr = {cpu_addr[31:`IC_OFFSET_BITS], {`IC_OFFSET_BITS{1'b0}}};

    // word from the stored line or from the arriving block
    assign hit_word  = data_array[index][word_sel*$bits(ifetch_pkg::word_t) +:
                                         $bits(ifetch_pkg::word_t)];
    assign fill_word = mem_data[word_sel*$bits(ifetch_pkg::word_t) +:
                                $bits(ifetch_pkg::word_t)];

    assign fill_done = (state == ifetch_pkg::IC_REFILL) && mem_ready;

    // only meaningful while comparing
    assign cpu_hit = (state == ifetch_pkg::IC_COMPARE) && valid[index] &&
                     (tag_array[index] == tag);

    always_comb begin
        next_state = state;
        case (state)
            ifetch_pkg::IC_IDLE: begin
                // fence wins over a fetch
                if (fence_i) begin
                    next_state = ifetch_pkg::IC_FENCE;
                end else if (cpu_req) begin
                    next_state = ifetch_pkg::IC_COMPARE;
                end
            end
            ifetch_pkg::IC_COMPARE: begin
                if (cpu_hit) begin
                    next_state = ifetch_pkg::IC_IDLE;
                end else begin
                    next_state = ifetch_pkg::IC_REFILL;
                end
            end
            ifetch_pkg::IC_REFILL: begin
                if (mem_ready) begin
                    next_state = ifetch_pkg::IC_IDLE;
                end
            end
            ifetch_pkg::IC_FENCE: begin
                next_state = ifetch_pkg::IC_IDLE;
            end
            default: begin
                next_state = ifetch_pkg::IC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ifetch_pkg::IC_IDLE;
            cpu_ready <= 1'b0;
            mem_req   <= 1'b0;
            valid     <= '0;
        end else begin
            state     <= next_state;
            cpu_ready <= ((state == ifetch_pkg::IC_COMPARE) && cpu_hit) ||
                         fill_done ||
                         (state == ifetch_pkg::IC_FENCE);

            // level held from miss until the block arrives
            case (state)
                ifetch_pkg::IC_COMPARE: mem_req <= !cpu_hit;
                ifetch_pkg::IC_REFILL:  mem_req <= !mem_ready;
                default:                mem_req <= 1'b0;
            endcase

            if (state == ifetch_pkg::IC_FENCE) begin
                valid <= '0;
            end else if (fill_done) begin
                valid[index] <= 1'b1;
            end
        end
    end

    // line fill
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_array[index]  <= tag;
            data_array[index] <= mem_data;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ifetch_pkg::IC_COMPARE) && cpu_hit) begin
            cpu_data <= hit_word;
        end else if (fill_done) begin
            cpu_data <= fill_word;
        end else if (state == ifetch_pkg::IC_FENCE) begin
            // fence returns zero
            cpu_data <= '0;
        end
    end

endmodule

// File: rtl/ifetch_macros.svh
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// cache geometry
`define IC_SETS 16
`define IC_BLOCK_BYTES 16

// derived address split
`define IC_OFFSET_BITS ($clog2(`IC_BLOCK_BYTES))
`define IC_INDEX_BITS ($clog2(`IC_SETS))
`define IC_WORD_BITS ($clog2(`IC_BLOCK_BYTES / 4))

// backing memory, block addresses wrap
`define IMEM_BLOCKS 64
`define IMEM_INDEX_BITS ($clog2(`IMEM_BLOCKS))

// cycles from accepted refill to mem_ready
`define IMEM_LATENCY 4

`endif

// File: rtl/ifetch_pkg.sv
`include "ifetch_macros.svh"

package ifetch_pkg;

    // byte address, always word aligned on fetch
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef logic [`IC_BLOCK_BYTES*8-1:0] block_t;

    typedef logic [`IC_INDEX_BITS-1:0] ic_index_t;

    // address bits above index and offset
    typedef logic [31-`IC_INDEX_BITS-`IC_OFFSET_BITS:0] ic_tag_t;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_COMPARE,
        IC_REFILL,
        IC_FENCE
    } ic_state_e;

    typedef enum logic [1:0] {
        IM_IDLE,
        IM_BUSY,
        IM_DONE
    } imem_state_e;

endpackage

// File: rtl/ifetch_top.sv
`timescale 1ns/100ps

module ifetch_top (
    input  logic                clk,
    input  logic                rst,

    // fetch port
    input  logic                cpu_req,
    input  ifetch_pkg::addr_t   cpu_addr,
    input  logic                fence_i,
    output ifetch_pkg::word_t   cpu_data,
    output logic                cpu_ready,
    output logic                cpu_hit,

    // store port into the backing memory
    input  logic                st_en,
    input  ifetch_pkg::addr_t   st_addr,
    input  ifetch_pkg::word_t   st_data
);

    // refill path between cache and memory
    logic                   mem_req;
    ifetch_pkg::addr_t      mem_addr;
    ifetch_pkg::block_t     mem_data;
    logic                   mem_ready;

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .fence_i   (fence_i),
        .cpu_data  (cpu_data),
        .cpu_ready (cpu_ready),
        .cpu_hit   (cpu_hit),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_ready (mem_ready)
    );

    imem_block u_imem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_ready (mem_ready),
        .st_en     (st_en),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

endmodule

// File: rtl/imem_block.sv
`timescale 1ns/100ps

`include "ifetch_macros.svh"

module imem_block (
    input  logic                clk,
    input  logic                rst,

    // refill port
    input  logic                mem_req,
    input  ifetch_pkg::addr_t   mem_addr,
    output ifetch_pkg::block_t  mem_data,
    output logic                mem_ready,

    // word store port, no wait
    input  logic                st_en,
    input  ifetch_pkg::addr_t   st_addr,
    input  ifetch_pkg::word_t   st_data
);

    typedef logic [$clog2(`IMEM_LATENCY + 1)-1:0] lat_cnt_t;

    ifetch_pkg::block_t         mem_array [`IMEM_BLOCKS];
    ifetch_pkg::imem_state_e    state;

    logic                       req_q;
    logic                       start;
    logic                       readout;
    lat_cnt_t                   wait_cnt;
    logic [`IMEM_INDEX_BITS-1:0] blk_idx;
    logic [`IMEM_INDEX_BITS-1:0] st_idx;
    logic [`IC_WORD_BITS-1:0]   st_word;
    ifetch_pkg::block_t         rd_block;

    // upper address bits alias away
    assign st_idx  = st_addr[`IC_OFFSET_BITS +: `IMEM_INDEX_BITS];
    assign st_word = st_addr[2 +: `IC_WORD_BITS];

    // rising edge of the request level
    assign start   = mem_req && !req_q && (state == ifetch_pkg::IM_IDLE);

    assign readout = (state == ifetch_pkg::IM_BUSY) && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (st_en) begin
            mem_array[st_idx][st_word*$bits(ifetch_pkg::word_t) +:
                              $bits(ifetch_pkg::word_t)] <= st_data;
        end
    end

    // merge a store that lands on the readout cycle
    always_comb begin
        rd_block = mem_array[blk_idx];
        if (st_en && (st_idx == blk_idx)) begin
            rd_block[st_word*$bits(ifetch_pkg::word_t) +:
                     $bits(ifetch_pkg::word_t)] = st_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ifetch_pkg::IM_IDLE;
            req_q     <= 1'b0;
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else begin
            req_q     <= mem_req;
            mem_ready <= 1'b0;
            case (state)
                ifetch_pkg::IM_IDLE: begin
                    if (start) begin
                        state    <= ifetch_pkg::IM_BUSY;
                        wait_cnt <= lat_cnt_t'(`IMEM_LATENCY - 1);
                    end
                end
                ifetch_pkg::IM_BUSY: begin
                    if (readout) begin
                        state     <= ifetch_pkg::IM_DONE;
                        mem_ready <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ifetch_pkg::IM_DONE: begin
                    state <= ifetch_pkg::IM_IDLE;
                end
                default: begin
                    state <= ifetch_pkg::IM_IDLE;
                end
            endcase
        end
    end

    // block address and readout
    always_ff @(posedge clk) begin
        if (start) begin
            blk_idx <= mem_addr[`IC_OFFSET_BITS +: `IMEM_INDEX_BITS];
        end
        if (readout) begin
            mem_data <= rd_block;
        end
    end

endmodule

// File: testbench/ifetch_chk.sv
`timescale 1ns/100ps

module ifetch_chk (
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_ready,
    input  logic    cpu_hit,
    input  logic    mem_req
);

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // ready is a single pulse
    ready_one_cycle: assert property (
        @(posedge clk) disable iff (rst) cpu_ready |=> !cpu_ready
    ) else begin
        $error("cpu_ready held for more than one cycle");
        fail_count = fail_count + 1;
    end

    // a hit completes on the next edge
    hit_then_ready: assert property (
        @(posedge clk) disable iff (rst) cpu_hit |=> cpu_ready
    ) else begin
        $error("cpu_hit not followed by cpu_ready");
        fail_count = fail_count + 1;
    end

    refill_excludes_ready: assert property (
        @(posedge clk) disable iff (rst) !(mem_req && cpu_ready)
    ) else begin
        $error("mem_req and cpu_ready high together");
        fail_count = fail_count + 1;
    end

    // outputs quiet while in reset
    quiet_in_reset: assert property (
        @(posedge clk) rst |-> (!cpu_ready && !mem_req && !cpu_hit)
    ) else begin
        $error("activity on cpu_ready, mem_req or cpu_hit during reset");
        fail_count = fail_count + 1;
    end

endmodule

bind ifetch_top ifetch_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .cpu_ready (cpu_ready),
    .cpu_hit   (cpu_hit),
    .mem_req   (mem_req)
);

// File: testbench/ifetch_tb.sv
`timescale 1ns/100ps

`include "ifetch_macros.svh"

module ifetch_tb;

    localparam logic [1:0] OP_FETCH = 2'd0;
    localparam logic [1:0] OP_STORE = 2'd1;
    localparam logic [1:0] OP_FENCE = 2'd2;

    localparam logic [31:0] SEED = 32'h9230;
    localparam int READY_TIMEOUT = `IMEM_LATENCY + 20;
    localparam int MEM_WORDS = `IMEM_BLOCKS * 4;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic        hit;
    } op_row_t;

    logic               clk;
    logic               rst;
    logic               cpu_req;
    ifetch_pkg::addr_t  cpu_addr;
    logic               fence_i;
    ifetch_pkg::word_t  cpu_data;
    logic               cpu_ready;
    logic               cpu_hit;
    logic               st_en;
    ifetch_pkg::addr_t  st_addr;
    ifetch_pkg::word_t  st_data;

    op_row_t            ops [$];

    // shadow of the backing memory and a model of the cache lines
    logic [31:0]        shadow [MEM_WORDS];
    logic               model_valid [16];
    logic [23:0]        model_tag [16];
    logic [31:0]        model_line [16][4];

    ifetch_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .fence_i   (fence_i),
        .cpu_data  (cpu_data),
        .cpu_ready (cpu_ready),
        .cpu_hit   (cpu_hit),
        .st_en     (st_en),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    always @(UUT.u_chk.fail_count) begin
        if (UUT.u_chk.fail_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end
    end

    task automatic add_op(input logic [1:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic hit);
        op_row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.hit  = hit;
        ops.push_back(r);
    endtask

    // direct mapped, index bits 7:4, tag bits 31:8, memory wraps at 64 blocks
    task automatic model_fetch(input logic [31:0] addr, output logic [31:0] word);
        int idx;
        int blk;
        idx = addr[7:4];
        blk = addr[9:4];
        if (!(model_valid[idx] && model_tag[idx] == addr[31:8])) begin
            for (int w = 0; w < 4; w++) begin
                model_line[idx][w] = shadow[blk*4 + w];
            end
            model_valid[idx] = 1'b1;
            model_tag[idx]   = addr[31:8];
        end
        word = model_line[idx][addr[3:2]];
    endtask

    // called on a falling edge, returns on the falling edge that sees cpu_ready
    task automatic wait_ready(output int cycles, output logic hit_seen);
        int n;
        logic seen;
        logic done;
        n    = 0;
        seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            n++;
            if (cpu_hit) begin
                seen = 1'b1;
            end
            fence_i = 1'b0;
            if (cpu_ready) begin
                done = 1'b1;
            end else if (n >= READY_TIMEOUT) begin
                stop_with_failure("cpu_ready did not arrive before the timeout");
            end
        end
        cycles   = n;
        hit_seen = seen;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
        st_en   = 1'b1;
        st_addr = addr;
        st_data = data;
        @(negedge clk);
        st_en = 1'b0;
        shadow[addr[9:2]] = data;
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic exp_hit);
        logic [31:0] exp_word;
        int cycles;
        logic hit_seen;
        model_fetch(addr, exp_word);
        cpu_addr = addr;
        cpu_req  = 1'b1;
        wait_ready(cycles, hit_seen);
        cpu_req = 1'b0;
        check("cpu_hit", hit_seen, exp_hit);
        check("cpu_data", cpu_data, exp_word);
        if (exp_hit) begin
            check("hit_latency", cycles, 2);
        end
    endtask

    task automatic run_fence();
        int cycles;
        logic hit_seen;
        fence_i = 1'b1;
        wait_ready(cycles, hit_seen);
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
        check("cpu_data", cpu_data, 32'h0);
        check("fence_latency", cycles, 2);
        check("cpu_hit", hit_seen, 1'b0);
    endtask

    task automatic build_table();
        add_op(OP_FETCH, 32'h0000_0040, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0040, 32'h0, 1'b1);
        add_op(OP_FETCH, 32'h0000_0044, 32'h0, 1'b1);
        add_op(OP_FETCH, 32'h0000_004C, 32'h0, 1'b1);
        add_op(OP_FETCH, 32'h0000_03F8, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_03F0, 32'h0, 1'b1);
        // same index, other tag
        add_op(OP_FETCH, 32'h0000_0140, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0048, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0144, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0040, 32'h0, 1'b0);
        // stale word until a fence
        add_op(OP_STORE, 32'h0000_0048, 32'hDEAD_BEEF, 1'b0);
        add_op(OP_FETCH, 32'h0000_0048, 32'h0, 1'b1);
        add_op(OP_FENCE, 32'h0, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0048, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_03F4, 32'h0, 1'b0);
        add_op(OP_STORE, 32'h0000_0104, 32'h1357_9BDF, 1'b0);
        add_op(OP_FETCH, 32'h0000_0104, 32'h0, 1'b0);
        // aliased addresses, distinct tags
        add_op(OP_FETCH, 32'h0000_1048, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_104C, 32'h0, 1'b1);
        add_op(OP_FETCH, 32'h0000_0048, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h8000_0100, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0104, 32'h0, 1'b0);
        add_op(OP_FETCH, 32'h0000_0100, 32'h0, 1'b1);
    endtask

    initial begin
        logic [31:0] lcg_state;
        rst      = 1'b1;
        cpu_req  = 1'b0;
        cpu_addr = '0;
        fence_i  = 1'b0;
        st_en    = 1'b0;
        st_addr  = '0;
        st_data  = '0;
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
        build_table();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("cpu_ready", cpu_ready, 1'b0);
        check("cpu_hit", cpu_hit, 1'b0);

        // fill every word of the memory
        lcg_state = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            lcg_state = lcg_next(lcg_state);
            store_word(i * 4, lcg_state);
        end

        foreach (ops[i]) begin
            case (ops[i].op)
                OP_FETCH: run_fetch(ops[i].addr, ops[i].hit);
                OP_STORE: store_word(ops[i].addr, ops[i].data);
                default:  run_fence();
            endcase
        end

        @(negedge clk);
        check("cpu_ready", cpu_ready, 1'b0);
        if (UUT.u_chk.fail_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
